// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

	typedef logic [31:0] word_t;    // data or address word
	typedef logic [4:0]  reg_addr_t;

	// major opcodes kept by this core
	typedef enum logic [6:0] {
		opc_op_imm = 7'b0010011,
		opc_op_reg = 7'b0110011,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	// branch behavior resolved in decode
	typedef enum logic [3:0] {
		br_none,
		br_beq,
		br_bne,
		br_blt,
		br_bge,
		br_bltu,
		br_bgeu,
		br_jump,      // jal
		br_jump_reg   // jalr
	} br_kind_e;

	localparam word_t link_offset = 32'd4;  // link value is pc + 4

endpackage

// ==== source/rv_core_ifs.sv ====
`timescale 1ns/1ps

// decoded fields from decoder to decode stage
interface dec_if;
	import rv_core_pkg::*;

	alu_op_e   alu_op;
	logic      wr_en;
	reg_addr_t rd;
	logic      rs1_used;
	logic      rs2_used;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t     imm;       // alu immediate
	word_t     br_imm;    // branch or jump offset
	logic      a_is_pc;
	logic      b_is_imm;
	br_kind_e  br_kind;
	logic      illegal;

	modport decoder (
		output alu_op, wr_en, rd, rs1_used, rs2_used, rs1, rs2,
		output imm, br_imm, a_is_pc, b_is_imm, br_kind, illegal
	);
	modport stage (
		input alu_op, wr_en, rd, rs1_used, rs2_used, rs1, rs2,
		input imm, br_imm, a_is_pc, b_is_imm, br_kind, illegal
	);
endinterface

// register file read ports
interface rf_rd_if;
	import rv_core_pkg::*;

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t     rs1_data;
	word_t     rs2_data;

	modport reader (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
	modport file (input rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

// decode/execute pipeline register contents
interface id_ex_if;
	import rv_core_pkg::*;

	logic      valid;
	alu_op_e   alu_op;
	word_t     op_a;
	word_t     op_b;
	reg_addr_t rd;
	logic      wr_en;

	modport src (output valid, alu_op, op_a, op_b, rd, wr_en);
	modport dst (input valid, alu_op, op_a, op_b, rd, wr_en);
endinterface

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
	input  rv_core_pkg::word_t inst_i,
	dec_if.decoder             dec
);
	import rv_core_pkg::*;

	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      i_imm;
	word_t      u_imm;
	word_t      b_imm;
	word_t      j_imm;
	logic       legal;
	logic       writes;

	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign i_imm = {{20{inst_i[31]}}, inst_i[31:20]};
	assign u_imm = {inst_i[31:12], 12'b0};
	assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	// funct3 map of op-imm and op-reg where alt picks sub or sra
	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  alu_sel = alt ? alu_sub : alu_add;
			3'b001:  alu_sel = alu_sll;
			3'b010:  alu_sel = alu_slt;
			3'b011:  alu_sel = alu_sltu;
			3'b100:  alu_sel = alu_xor;
			3'b101:  alu_sel = alt ? alu_sra : alu_srl;
			3'b110:  alu_sel = alu_or;
			default: alu_sel = alu_and;
		endcase
	endfunction

	always_comb begin
		legal        = 1'b0;
		writes       = 1'b0;
		dec.alu_op   = alu_add;
		dec.rd       = inst_i[11:7];
		dec.rs1      = inst_i[19:15];
		dec.rs2      = inst_i[24:20];
		dec.rs1_used = 1'b0;
		dec.rs2_used = 1'b0;
		dec.imm      = i_imm;
		dec.br_imm   = b_imm;
		dec.a_is_pc  = 1'b0;
		dec.b_is_imm = 1'b0;
		dec.br_kind  = br_none;

		case (opcode_e'(inst_i[6:0]))
			opc_op_imm: begin
				dec.rs1_used = 1'b1;
				dec.b_is_imm = 1'b1;
				// bit 30 is part of the immediate except for shifts
				dec.alu_op   = alu_sel(funct3, (funct3 == 3'b101) && inst_i[30]);
				writes       = 1'b1;
				case (funct3)
					3'b001:  legal = (funct7 == 7'b0000000);
					3'b101:  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					default: legal = 1'b1;
				endcase
			end
			opc_op_reg: begin
				dec.rs1_used = 1'b1;
				dec.rs2_used = 1'b1;
				dec.alu_op   = alu_sel(funct3, inst_i[30]);
				writes       = 1'b1;
				legal        = (funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			opc_lui: begin
				dec.rs1      = '0;    // x0 + imm
				dec.b_is_imm = 1'b1;
				dec.imm      = u_imm;
				writes       = 1'b1;
				legal        = 1'b1;
			end
			opc_auipc: begin
				dec.a_is_pc  = 1'b1;
				dec.b_is_imm = 1'b1;
				dec.imm      = u_imm;
				writes       = 1'b1;
				legal        = 1'b1;
			end
			opc_jal: begin
				dec.a_is_pc  = 1'b1;  // alu makes the link value
				dec.b_is_imm = 1'b1;
				dec.imm      = link_offset;
				dec.br_imm   = j_imm;
				dec.br_kind  = br_jump;
				writes       = 1'b1;
				legal        = 1'b1;
			end
			opc_jalr: begin
				dec.rs1_used = 1'b1;
				dec.a_is_pc  = 1'b1;
				dec.b_is_imm = 1'b1;
				dec.imm      = link_offset;
				dec.br_imm   = i_imm;
				dec.br_kind  = br_jump_reg;
				writes       = 1'b1;
				legal        = (funct3 == 3'b000);
			end
			opc_branch: begin
				dec.rs1_used = 1'b1;
				dec.rs2_used = 1'b1;
				legal        = 1'b1;
				case (funct3)
					3'b000:  dec.br_kind = br_beq;
					3'b001:  dec.br_kind = br_bne;
					3'b100:  dec.br_kind = br_blt;
					3'b101:  dec.br_kind = br_bge;
					3'b110:  dec.br_kind = br_bltu;
					3'b111:  dec.br_kind = br_bgeu;
					default: legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase

		dec.illegal = ~legal;
		dec.wr_en   = legal & writes & (inst_i[11:7] != 5'd0);  // x0 never written
		if (!legal) begin
			dec.br_kind = br_none;
		end
	end

endmodule

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
	input  rv_core_pkg::br_kind_e br_kind_i,
	input  rv_core_pkg::word_t    rs1_i,
	input  rv_core_pkg::word_t    rs2_i,
	input  rv_core_pkg::word_t    pc_i,
	input  rv_core_pkg::word_t    imm_i,
	output logic                  taken_o,
	output rv_core_pkg::word_t    target_o
);
	import rv_core_pkg::*;

	logic  eq;
	logic  lt;
	logic  ltu;
	word_t reg_sum;

	assign eq      = (rs1_i == rs2_i);
	assign lt      = ($signed(rs1_i) < $signed(rs2_i));
	assign ltu     = (rs1_i < rs2_i);
	assign reg_sum = rs1_i + imm_i;

	always_comb begin
		case (br_kind_i)
			br_beq:                taken_o = eq;
			br_bne:                taken_o = ~eq;
			br_blt:                taken_o = lt;
			br_bge:                taken_o = ~lt;
			br_bltu:               taken_o = ltu;
			br_bgeu:               taken_o = ~ltu;
			br_jump, br_jump_reg:  taken_o = 1'b1;
			default:               taken_o = 1'b0;
		endcase
	end

	// jalr clears bit 0 of the sum
	assign target_o = (br_kind_i == br_jump_reg) ? {reg_sum[31:1], 1'b0} : pc_i + imm_i;

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic                   clk,
	input  logic                   rst_n_i,
	rf_rd_if.file                  rd,
	input  logic                   wb_valid_i,
	input  rv_core_pkg::reg_addr_t wb_rd_i,
	input  rv_core_pkg::word_t     wb_data_i
);
	import rv_core_pkg::*;

	word_t regs [1:31];  // x0 has no storage

	always_ff @(posedge clk) begin
		if (wb_valid_i) begin
			regs[wb_rd_i] <= wb_data_i;
		end
	end

	assign rd.rs1_data = (rd.rs1_addr == '0) ? '0 : regs[rd.rs1_addr];
	assign rd.rs2_data = (rd.rs2_addr == '0) ? '0 : regs[rd.rs2_addr];

	// decode drops x0 writes two stages earlier
	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_valid_i |-> (wb_rd_i != '0))
		else $error("regfile: write to x0");

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   inst_valid_i,
	input  rv_core_pkg::word_t     inst_i,
	input  rv_core_pkg::word_t     pc_i,
	rf_rd_if.reader                rf,
	id_ex_if.src                   ex,
	input  logic                   ex_fwd_en_i,
	input  rv_core_pkg::reg_addr_t ex_fwd_rd_i,
	input  rv_core_pkg::word_t     ex_fwd_data_i,
	input  logic                   wb_valid_i,
	input  rv_core_pkg::reg_addr_t wb_rd_i,
	input  rv_core_pkg::word_t     wb_data_i,
	output logic                   branch_taken_o,
	output rv_core_pkg::word_t     branch_target_o,
	output logic                   illegal_o
);
	import rv_core_pkg::*;

	logic  ir_valid;
	word_t ir_inst;
	word_t ir_pc;
	word_t rs1_val;
	word_t rs2_val;
	logic  br_taken;
	word_t br_target;

	dec_if dec ();

	instr_decoder u_instr_decoder (
		.inst_i (ir_inst),
		.dec    (dec)
	);

	// youngest producer wins over writeback and then the file
	function automatic word_t fwd_operand(input reg_addr_t addr, input logic used,
			input word_t file_data);
		if (!used || addr == '0) begin
			return '0;
		end else if (ex_fwd_en_i && ex_fwd_rd_i == addr) begin
			return ex_fwd_data_i;
		end else if (wb_valid_i && wb_rd_i == addr) begin
			return wb_data_i;
		end
		return file_data;
	endfunction

	assign rf.rs1_addr = dec.rs1;
	assign rf.rs2_addr = dec.rs2;

	always_comb begin
		rs1_val = fwd_operand(dec.rs1, dec.rs1_used, rf.rs1_data);
		rs2_val = fwd_operand(dec.rs2, dec.rs2_used, rf.rs2_data);
	end

	branch_unit u_branch_unit (
		.br_kind_i (dec.br_kind),
		.rs1_i     (rs1_val),
		.rs2_i     (rs2_val),
		.pc_i      (ir_pc),
		.imm_i     (dec.br_imm),
		.taken_o   (br_taken),
		.target_o  (br_target)
	);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ir_valid <= 1'b0;
		end else begin
			ir_valid <= inst_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid_i) begin
			ir_inst <= inst_i;
			ir_pc   <= pc_i;
		end
	end

	// illegal ones leave a bubble
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ex.valid       <= 1'b0;
			ex.wr_en       <= 1'b0;
			branch_taken_o <= 1'b0;
			illegal_o      <= 1'b0;
		end else begin
			ex.valid       <= ir_valid & ~dec.illegal;
			ex.wr_en       <= ir_valid & dec.wr_en;
			branch_taken_o <= ir_valid & br_taken;
			illegal_o      <= ir_valid & dec.illegal;
		end
	end

	always_ff @(posedge clk) begin
		ex.alu_op       <= dec.alu_op;
		ex.op_a         <= dec.a_is_pc ? ir_pc : rs1_val;
		ex.op_b         <= dec.b_is_imm ? dec.imm : rs2_val;
		ex.rd           <= dec.rd;
		branch_target_o <= br_target;
	end

	// a taken branch comes from a held legal instruction one edge earlier
	a_branch_src: assert property (@(posedge clk) disable iff (!rst_n_i)
		branch_taken_o |-> $past(ir_valid && !dec.illegal))
		else $error("decode_stage: branch taken without a valid instruction");

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                   clk,
	input  logic                   rst_n_i,
	id_ex_if.dst                   ex,
	output logic                   ex_fwd_en_o,
	output rv_core_pkg::reg_addr_t ex_fwd_rd_o,
	output rv_core_pkg::word_t     ex_fwd_data_o,
	output logic                   wb_valid_o,
	output rv_core_pkg::reg_addr_t wb_rd_o,
	output rv_core_pkg::word_t     wb_data_o
);
	import rv_core_pkg::*;

	word_t      alu_res;
	logic [4:0] shamt;

	assign shamt = ex.op_b[4:0];  // low five bits only

	always_comb begin
		case (ex.alu_op)
			alu_add:  alu_res = ex.op_a + ex.op_b;
			alu_sub:  alu_res = ex.op_a - ex.op_b;
			alu_sll:  alu_res = ex.op_a << shamt;
			alu_slt:  alu_res = {31'b0, $signed(ex.op_a) < $signed(ex.op_b)};
			alu_sltu: alu_res = {31'b0, ex.op_a < ex.op_b};
			alu_xor:  alu_res = ex.op_a ^ ex.op_b;
			alu_srl:  alu_res = ex.op_a >> shamt;
			alu_sra:  alu_res = $signed(ex.op_a) >>> shamt;
			alu_or:   alu_res = ex.op_a | ex.op_b;
			alu_and:  alu_res = ex.op_a & ex.op_b;
			default:  alu_res = '0;
		endcase
	end

	// same cycle result back to decode
	assign ex_fwd_en_o   = ex.valid & ex.wr_en;
	assign ex_fwd_rd_o   = ex.rd;
	assign ex_fwd_data_o = alu_res;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= ex.valid & ex.wr_en;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd_o   <= ex.rd;
		wb_data_o <= alu_res;
	end

	a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_valid_o |-> (wb_rd_o != '0))
		else $error("execute_stage: writeback to x0");

endmodule

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   inst_valid_i,
	input  rv_core_pkg::word_t     inst_i,
	input  rv_core_pkg::word_t     pc_i,
	output logic                   branch_taken_o,
	output rv_core_pkg::word_t     branch_target_o,
	output logic                   illegal_o,
	output logic                   wb_valid_o,
	output rv_core_pkg::reg_addr_t wb_rd_o,
	output rv_core_pkg::word_t     wb_data_o
);

	logic                   ex_fwd_en;
	rv_core_pkg::reg_addr_t ex_fwd_rd;
	rv_core_pkg::word_t     ex_fwd_data;

	rf_rd_if u_rf_rd ();
	id_ex_if u_id_ex ();

	decode_stage u_decode_stage (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.inst_valid_i    (inst_valid_i),
		.inst_i          (inst_i),
		.pc_i            (pc_i),
		.rf              (u_rf_rd),
		.ex              (u_id_ex),
		.ex_fwd_en_i     (ex_fwd_en),
		.ex_fwd_rd_i     (ex_fwd_rd),
		.ex_fwd_data_i   (ex_fwd_data),
		.wb_valid_i      (wb_valid_o),
		.wb_rd_i         (wb_rd_o),
		.wb_data_i       (wb_data_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o),
		.illegal_o       (illegal_o)
	);

	execute_stage u_execute_stage (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.ex            (u_id_ex),
		.ex_fwd_en_o   (ex_fwd_en),
		.ex_fwd_rd_o   (ex_fwd_rd),
		.ex_fwd_data_o (ex_fwd_data),
		.wb_valid_o    (wb_valid_o),
		.wb_rd_o       (wb_rd_o),
		.wb_data_o     (wb_data_o)
	);

	regfile u_regfile (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rd         (u_rf_rd),
		.wb_valid_i (wb_valid_o),
		.wb_rd_i    (wb_rd_o),
		.wb_data_i  (wb_data_o)
	);

endmodule

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
	import rv_core_pkg::*;

	// issue slots over all tests including five drain cycles per test
	localparam int n_slots = 76 + 36 + 28 + 5 + 8 + 4 + 6 * 5;
	localparam logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	localparam logic [4:0] pair_a [4] = '{5'd20, 5'd22, 5'd23, 5'd20};
	localparam logic [4:0] pair_b [4] = '{5'd21, 5'd23, 5'd22, 5'd23};

	// expected outcome of one issue slot
	typedef struct packed {
		logic       wr;
		logic [4:0] rd;
		word_t      data;
		logic       taken;
		word_t      target;
		logic       bad;
	} exp_t;

	logic      clk = 1'b0;
	logic      rst_n_i;
	logic      inst_valid_i;
	word_t     inst_i;
	word_t     pc_i;
	logic      branch_taken_o;
	word_t     branch_target_o;
	logic      illegal_o;
	logic      wb_valid_o;
	reg_addr_t wb_rd_o;
	word_t     wb_data_o;

	exp_t   e0;
	exp_t   e1;
	exp_t   e2;   // lines up with branch outputs
	exp_t   e3;   // lines up with writeback
	word_t  shadow [0:31];
	word_t  pc;
	integer seed;
	string  test_name;
	int     errors = 0;
	int     errors_base = 0;
	int     passed = 0;
	int     failed = 0;

	always #20 clk = ~clk;

	rv_core_top u_rv_core_top (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.inst_valid_i    (inst_valid_i),
		.inst_i          (inst_i),
		.pc_i            (pc_i),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o),
		.illegal_o       (illegal_o),
		.wb_valid_o      (wb_valid_o),
		.wb_rd_o         (wb_rd_o),
		.wb_data_o       (wb_data_o)
	);

	function automatic word_t itype(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t rtype(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic word_t btype(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
	endfunction

	function automatic word_t jtype(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
			input word_t a, input word_t b);
		word_t y;
		case (f3)
			3'd0: y = alt ? a - b : a + b;
			3'd1: y = a << b[4:0];
			3'd2: y = {31'd0, $signed(a) < $signed(b)};
			3'd3: y = {31'd0, a < b};
			3'd4: y = a ^ b;
			3'd5: begin
				if (alt) begin
					y = $signed(a) >>> b[4:0];
				end else begin
					y = a >> b[4:0];
				end
			end
			3'd6: y = a | b;
			default: y = a & b;
		endcase
		return y;
	endfunction

	// ISA reference for one instruction against the shadow registers
	function automatic exp_t predict(input word_t inst, input word_t at_pc);
		exp_t       e;
		word_t      a;
		word_t      b;
		word_t      imm_i;
		logic [2:0] f3;
		a     = shadow[inst[19:15]];
		b     = shadow[inst[24:20]];
		f3    = inst[14:12];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		e     = '0;
		e.rd  = inst[11:7];
		case (inst[6:0])
			7'h13: begin
				e.wr   = 1'b1;
				e.data = alu_result(f3, f3 == 3'd5 && inst[30], a, imm_i);
			end
			7'h33: begin
				e.wr   = 1'b1;
				e.data = alu_result(f3, inst[30], a, b);
				if (inst[31:25] != 7'h00 &&
						!(inst[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
					e.bad = 1'b1;   // mul/div group is not kept
				end
			end
			7'h37: begin
				e.wr   = 1'b1;
				e.data = {inst[31:12], 12'h000};
			end
			7'h17: begin
				e.wr   = 1'b1;
				e.data = at_pc + {inst[31:12], 12'h000};
			end
			7'h6f: begin
				e.wr     = 1'b1;
				e.data   = at_pc + 32'd4;
				e.taken  = 1'b1;
				e.target = at_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			7'h67: begin
				e.wr     = 1'b1;
				e.data   = at_pc + 32'd4;
				e.taken  = 1'b1;
				e.target = (a + imm_i) & ~32'd1;
			end
			7'h63: begin
				case (f3)
					3'd0: e.taken = (a == b);
					3'd1: e.taken = (a != b);
					3'd4: e.taken = ($signed(a) < $signed(b));
					3'd5: e.taken = ($signed(a) >= $signed(b));
					3'd6: e.taken = (a < b);
					3'd7: e.taken = (a >= b);
					default: e.bad = 1'b1;
				endcase
				e.target = at_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			default: e.bad = 1'b1;
		endcase
		if (e.bad) begin
			e.taken = 1'b0;
		end
		e.wr = e.wr & ~e.bad & (e.rd != 5'd0);
		return e;
	endfunction

	task automatic issue(input word_t inst);
		exp_t e;
		e = predict(inst, pc);
		if (e.wr) begin
			shadow[e.rd] = e.data;
		end
		@(posedge clk);
		inst_valid_i <= 1'b1;
		inst_i       <= inst;
		pc_i         <= pc;
		e0           <= e;
		pc = pc + 32'd4;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			inst_valid_i <= 1'b0;
			e0           <= '0;
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		errors_base = errors;
	endtask

	task automatic close_test();
		int n;
		idle(5);   // last slot reaches writeback after four edges
		n = errors - errors_base;
		$display("test %s: %s, %0d mismatches", test_name, (n == 0) ? "passed" : "failed", n);
		if (n == 0) begin
			passed++;
		end else begin
			failed++;
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n_i) begin
			e1 <= '0;
			e2 <= '0;
			e3 <= '0;
		end else begin
			e1 <= e0;
			e2 <= e1;
			e3 <= e2;
		end
	end

	a_wb_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_valid_o == e3.wr)
		else begin
			errors++;
			$display("** Error %s: writeback strobe expected %0b, actual %0b", test_name,
				$sampled(e3.wr), $sampled(wb_valid_o));
		end

	a_wb_value: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_valid_o |-> (wb_rd_o == e3.rd && wb_data_o == e3.data))
		else begin
			errors++;
			$display("** Error %s: writeback expected x%0d=%h, actual x%0d=%h", test_name,
				$sampled(e3.rd), $sampled(e3.data), $sampled(wb_rd_o), $sampled(wb_data_o));
		end

	a_branch_taken: assert property (@(posedge clk) disable iff (!rst_n_i)
		branch_taken_o == e2.taken)
		else begin
			errors++;
			$display("** Error %s: branch taken expected %0b, actual %0b", test_name,
				$sampled(e2.taken), $sampled(branch_taken_o));
		end

	a_branch_target: assert property (@(posedge clk) disable iff (!rst_n_i)
		e2.taken |-> branch_target_o == e2.target)
		else begin
			errors++;
			$display("** Error %s: branch target expected %h, actual %h", test_name,
				$sampled(e2.target), $sampled(branch_target_o));
		end

	a_illegal: assert property (@(posedge clk) disable iff (!rst_n_i)
		illegal_o == e2.bad)
		else begin
			errors++;
			$display("** Error %s: illegal flag expected %0b, actual %0b", test_name,
				$sampled(e2.bad), $sampled(illegal_o));
		end

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n_i |=> (!wb_valid_o && !branch_taken_o && !illegal_o))
		else begin
			errors++;
			$display("outputs still active in the cycle after a reset edge");
		end

	initial begin
		#(n_slots * 160 + 10 * 40);
		$display("watchdog: run did not finish within %0d ns", n_slots * 160 + 10 * 40);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		word_t      r;
		logic [2:0] f3;
		logic [11:0] imm;
		seed = 32'h8ebb_131f;
		pc   = 32'h0000_1000;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		rst_n_i      <= 1'b0;
		inst_valid_i <= 1'b0;
		inst_i       <= '0;
		pc_i         <= '0;
		e0           <= '0;
		repeat (10) @(posedge clk);
		rst_n_i <= 1'b1;

		start_test("imm_alu");
		for (int i = 1; i < 32; i++) begin
			r = $random(seed);
			issue(itype(r[11:0], 5'd0, 3'd0, i[4:0], 7'h13));   // fill every register
		end
		issue(itype(12'hff8, 5'd0, 3'd0, 5'd5, 7'h13));   // x5 = -8
		issue(itype(12'h001, 5'd5, 3'd2, 5'd6, 7'h13));   // slti of a negative value against 1
		issue(itype(12'h001, 5'd5, 3'd3, 5'd7, 7'h13));   // sltiu sees a huge value
		issue(itype(12'hfff, 5'd5, 3'd3, 5'd9, 7'h13));
		issue(itype(12'h402, 5'd5, 3'd5, 5'd8, 7'h13));   // srai by 2
		for (int i = 0; i < 40; i++) begin
			r   = $random(seed);
			f3  = r[14:12];
			imm = r[31:20];
			if (f3 == 3'd1) begin
				imm[11:5] = 7'h00;
			end else if (f3 == 3'd5) begin
				imm[11:5] = {1'b0, r[30], 5'b0};
			end
			issue(itype(imm, r[19:15], f3, r[11:7], 7'h13));
		end
		close_test();

		// rd rotates over d registers so each read is d slots after its write
		start_test("reg_chain");
		for (int d = 1; d <= 3; d++) begin
			for (int i = 0; i < 12; i++) begin
				r  = $random(seed);
				f3 = r[14:12];
				issue(rtype({1'b0, r[30] && (f3 == 3'd0 || f3 == 3'd5), 5'b0},
					{1'b1, r[23:20]}, 5'(1 + i % d), f3, 5'(1 + i % d)));
			end
		end
		close_test();

		start_test("branch");
		issue(itype(12'd5, 5'd0, 3'd0, 5'd20, 7'h13));
		issue(itype(12'd5, 5'd0, 3'd0, 5'd21, 7'h13));
		issue(itype(12'hffd, 5'd0, 3'd0, 5'd22, 7'h13));   // -3
		issue(itype(12'd7, 5'd0, 3'd0, 5'd23, 7'h13));
		for (int b = 0; b < 6; b++) begin
			for (int p = 0; p < 4; p++) begin
				r = $random(seed);
				issue(btype({r[12:1], 1'b0}, pair_b[p], pair_a[p], br_f3[b]));
			end
		end
		close_test();

		start_test("jump");
		r = $random(seed);
		issue(jtype({r[20:1], 1'b0}, 5'd9));
		issue(jtype(21'h1ffff8, 5'd0));                    // no link for x0
		issue(itype(12'h124, 5'd0, 3'd0, 5'd12, 7'h13));
		issue(itype(12'h0a5, 5'd12, 3'd0, 5'd13, 7'h67));  // odd sum from a forwarded rs1
		issue(itype(12'hf01, 5'd13, 3'd0, 5'd0, 7'h67));
		close_test();

		start_test("upper");
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			issue({r[31:12], r[11:7], (i < 4) ? 7'h37 : 7'h17});
		end
		close_test();

		start_test("illegal");
		issue(32'h0000_007f);
		issue(itype(12'h010, 5'd1, 3'd2, 5'd3, 7'h03));    // load is not kept
		issue(rtype(7'h01, 5'd2, 5'd1, 3'd0, 5'd3));        // mul is not kept
		issue(itype(12'h000, 5'd3, 3'd0, 5'd4, 7'h13));    // x3 must be unchanged
		close_test();

		$display("tests passed: %0d, failed: %0d, mismatches: %0d", passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
source/rv_core_pkg.sv
source/rv_core_ifs.sv
source/instr_decoder.sv
source/branch_unit.sv
source/regfile.sv
source/decode_stage.sv
source/execute_stage.sv
source/rv_core_top.sv
bench/tb_rv_core.sv

// ==== Makefile ====
.PHONY: run clean

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core > sim.log 2>&1 || true
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log
	grep -q "STATUS: PASS" sim.log

obj_dir/Vtb_rv_core: sim.f $(wildcard source/*.sv) $(wildcard bench/*.sv)
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_rv_core -f sim.f

clean:
	rm -rf obj_dir sim.log
